//--- rtl/music_pkg.sv
package music_pkg;

	////////////////////////////////////////
	// Note and register types
	////////////////////////////////////////

	typedef struct packed {
		logic [5:0] dur;    // Beats minus one
		logic [3:0] pitch;  // 0 is a rest
	} note_t;

	typedef struct packed {
		logic        play;
		logic [15:0] tempo_div;  // Clocks per beat, never 0
		logic        restart;    // Single-cycle pulse
	} cfg_t;

	localparam logic [1:0] CFG_ADDR_CTRL  = 2'd0;  // bit 0 play, bit 1 restart
	localparam logic [1:0] CFG_ADDR_TEMPO = 2'd1;

	localparam int NUM_PITCH = 10;
	localparam int SCORE_LEN = 133;

	// Base half-periods in clocks, C4 up to D5 at 50 MHz with a shift of 11
	localparam logic [0:NUM_PITCH-1][11:0] HALF_PERIOD = '{
		12'd2, 12'd47, 12'd42, 12'd37, 12'd35,
		12'd31, 12'd28, 12'd25, 12'd23, 12'd21
	};

	////////////////////////////////////////
	// Score
	////////////////////////////////////////

	localparam note_t [0:SCORE_LEN-1] SCORE = '{
		'{6'd47, 4'd0}, '{6'd15, 4'd2}, '{6'd15, 4'd5}, '{6'd7, 4'd4}, '{6'd7, 4'd5},
		'{6'd15, 4'd6}, '{6'd7, 4'd5}, '{6'd7, 4'd6}, '{6'd7, 4'd7}, '{6'd7, 4'd7},
		'{6'd7, 4'd8}, '{6'd7, 4'd7}, '{6'd15, 4'd3}, '{6'd7, 4'd6}, '{6'd7, 4'd6},
		'{6'd15, 4'd5}, '{6'd7, 4'd5}, '{6'd7, 4'd5}, '{6'd15, 4'd4}, '{6'd7, 4'd3},
		'{6'd7, 4'd4}, '{6'd47, 4'd5}, '{6'd15, 4'd2}, '{6'd15, 4'd5}, '{6'd7, 4'd4},
		'{6'd7, 4'd5}, '{6'd15, 4'd6}, '{6'd7, 4'd5}, '{6'd7, 4'd6}, '{6'd7, 4'd7},
		'{6'd7, 4'd7}, '{6'd7, 4'd8}, '{6'd7, 4'd7}, '{6'd15, 4'd3}, '{6'd7, 4'd6},
		'{6'd7, 4'd6}, '{6'd15, 4'd5}, '{6'd7, 4'd5}, '{6'd7, 4'd5}, '{6'd15, 4'd4},
		'{6'd7, 4'd3}, '{6'd7, 4'd4}, '{6'd47, 4'd5}, '{6'd7, 4'd5}, '{6'd7, 4'd7},
		'{6'd15, 4'd9}, '{6'd7, 4'd7}, '{6'd7, 4'd6}, '{6'd15, 4'd5}, '{6'd7, 4'd4},
		'{6'd7, 4'd5}, '{6'd7, 4'd6}, '{6'd7, 4'd5}, '{6'd7, 4'd4}, '{6'd7, 4'd3},
		'{6'd15, 4'd2}, '{6'd7, 4'd5}, '{6'd7, 4'd7}, '{6'd15, 4'd9}, '{6'd7, 4'd7},
		'{6'd7, 4'd6}, '{6'd7, 4'd5}, '{6'd3, 4'd6}, '{6'd3, 4'd5}, '{6'd7, 4'd4},
		'{6'd7, 4'd5}, '{6'd47, 4'd6}, '{6'd7, 4'd0}, '{6'd7, 4'd2}, '{6'd7, 4'd5},
		'{6'd7, 4'd5}, '{6'd15, 4'd0}, '{6'd7, 4'd6}, '{6'd15, 4'd6}, '{6'd7, 4'd0},
		'{6'd7, 4'd7}, '{6'd7, 4'd7}, '{6'd7, 4'd8}, '{6'd7, 4'd7}, '{6'd15, 4'd3},
		'{6'd7, 4'd6}, '{6'd7, 4'd6}, '{6'd15, 4'd5}, '{6'd7, 4'd5}, '{6'd7, 4'd5},
		'{6'd15, 4'd4}, '{6'd7, 4'd3}, '{6'd7, 4'd4}, '{6'd47, 4'd5}, '{6'd15, 4'd2},
		'{6'd15, 4'd5}, '{6'd7, 4'd2}, '{6'd7, 4'd2}, '{6'd7, 4'd3}, '{6'd7, 4'd3},
		'{6'd15, 4'd2}, '{6'd15, 4'd1}, '{6'd15, 4'd2}, '{6'd15, 4'd1}, '{6'd7, 4'd2},
		'{6'd7, 4'd2}, '{6'd15, 4'd5}, '{6'd7, 4'd2}, '{6'd7, 4'd2}, '{6'd7, 4'd3},
		'{6'd7, 4'd3}, '{6'd15, 4'd2}, '{6'd15, 4'd1}, '{6'd15, 4'd2}, '{6'd15, 4'd1},
		'{6'd7, 4'd2}, '{6'd7, 4'd2}, '{6'd7, 4'd5}, '{6'd7, 4'd5}, '{6'd15, 4'd0},
		'{6'd7, 4'd6}, '{6'd15, 4'd6}, '{6'd7, 4'd0}, '{6'd7, 4'd7}, '{6'd7, 4'd7},
		'{6'd7, 4'd8}, '{6'd7, 4'd7}, '{6'd15, 4'd3}, '{6'd7, 4'd6}, '{6'd7, 4'd6},
		'{6'd15, 4'd5}, '{6'd15, 4'd4}, '{6'd7, 4'd3}, '{6'd7, 4'd4}, '{6'd15, 4'd5},
		'{6'd15, 4'd0}, '{6'd63, 4'd0}, '{6'd63, 4'd0}  // Long tail rest
	};

endpackage

//--- rtl/player_regs.sv
`timescale 1ns/1ps

module player_regs import music_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        cfg_we,
	input  logic [1:0]  cfg_addr,
	input  logic [15:0] cfg_wdata,
	output cfg_t        cfg
);

	logic ctrl_wr;
	logic tempo_wr;

	assign ctrl_wr  = cfg_we && (cfg_addr == CFG_ADDR_CTRL);
	assign tempo_wr = cfg_we && (cfg_addr == CFG_ADDR_TEMPO);

	////////////////////////////////////////
	// Register writes
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cfg.play      <= 1'b0;
			cfg.tempo_div <= 16'd1;
			cfg.restart   <= 1'b0;
		end
		else
		begin
			cfg.restart <= ctrl_wr && cfg_wdata[1];  // Self-clearing
			if (ctrl_wr)
				cfg.play <= cfg_wdata[0];
			// Zero would stall the prescaler, so it reads as one
			if (tempo_wr)
				cfg.tempo_div <= (cfg_wdata == 16'd0) ? 16'd1 : cfg_wdata;
		end
	end

	// Other addresses are ignored

	a_restart_pulse: assert property (
		@(posedge clk) disable iff (!rst_n)
		cfg.restart |=> !cfg.restart
	);

endmodule

//--- rtl/note_timer.sv
`timescale 1ns/1ps

module note_timer import music_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  cfg_t  cfg,
	input  note_t cur_note,
	output logic  advance
);

	logic [15:0] pre_cnt;   // Clocks within the beat
	logic [5:0]  beat_cnt;  // Beats within the note
	logic        beat;

	// Greater-or-equal so a smaller tempo written mid-beat takes effect at once
	assign beat    = cfg.play && (pre_cnt >= cfg.tempo_div - 16'd1);
	assign advance = beat && (beat_cnt == cur_note.dur);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pre_cnt  <= '0;
			beat_cnt <= '0;
		end
		else if (cfg.restart)
		begin
			pre_cnt  <= '0;
			beat_cnt <= '0;
		end
		else if (beat)
		begin
			pre_cnt  <= '0;
			beat_cnt <= advance ? 6'd0 : beat_cnt + 6'd1;
		end
		else if (cfg.play)
			pre_cnt <= pre_cnt + 16'd1;  // Frozen while paused
	end

	// Beat count never runs past the note the ring is showing
	a_beat_in_note: assert property (
		@(posedge clk) disable iff (!rst_n)
		beat_cnt <= cur_note.dur
	);

endmodule

//--- rtl/score_ring.sv
`timescale 1ns/1ps

module score_ring import music_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  cfg_t  cfg,
	input  logic  advance,
	output note_t cur_note,
	output logic  note_start
);

	note_t [0:SCORE_LEN-1] ring;  // Head at index 0

	assign cur_note = ring[0];

	////////////////////////////////////////
	// Note store
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ring <= SCORE;
		else if (cfg.restart)
			ring <= SCORE;  // Back to the top of the tune
		else if (advance)
			ring <= {ring[1:SCORE_LEN-1], ring[0]};  // Head wraps to tail
	end

	// First cycle of every new note
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			note_start <= 1'b0;
		else
			note_start <= advance || cfg.restart;
	end

	// Notes last at least one beat, so only a restart can follow a start
	a_start_pulse: assert property (
		@(posedge clk) disable iff (!rst_n)
		(note_start && !cfg.restart) |=> !note_start
	);

endmodule

//--- rtl/tone_gen.sv
`timescale 1ns/1ps

module tone_gen import music_pkg::*;
#(
	parameter int TONE_SHIFT = 0
)
(
	input  logic  clk,
	input  logic  rst_n,
	input  cfg_t  cfg,
	input  note_t cur_note,
	input  logic  note_start,
	output logic  speaker
);

	localparam int CW = 12 + TONE_SHIFT;

	logic [11:0]   half;
	logic [CW-1:0] limit;
	logic [CW-1:0] cnt;
	logic          rest;

	////////////////////////////////////////
	// Pitch lookup
	////////////////////////////////////////

	assign rest = (cur_note.pitch == 4'd0) || (cur_note.pitch >= 4'(NUM_PITCH));

	always_comb
	begin
		half = HALF_PERIOD[0];
		if (!rest)
			half = HALF_PERIOD[cur_note.pitch];
	end

	assign limit = (CW'(half) << TONE_SHIFT) - CW'(1);

	////////////////////////////////////////
	// Square wave
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt     <= '0;
			speaker <= 1'b0;
		end
		else if (note_start || rest)
		begin
			cnt     <= '0;
			speaker <= 1'b0;
		end
		else if (!cfg.play)
			speaker <= 1'b0;  // Counter holds its place
		else if (cnt == limit)
		begin
			cnt     <= '0;
			speaker <= !speaker;
		end
		else
			cnt <= cnt + CW'(1);
	end

	// Silence lands one cycle after the ring switches to a rest
	a_rest_quiet: assert property (
		@(posedge clk) disable iff (!rst_n)
		(cur_note.pitch == 4'd0 && !note_start) |-> !speaker
	);

endmodule

//--- rtl/music_player.sv
`timescale 1ns/1ps

module music_player import music_pkg::*;
#(
	parameter int TONE_SHIFT = 0  // 11 for a 50 MHz board clock
)
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        cfg_we,
	input  logic [1:0]  cfg_addr,
	input  logic [15:0] cfg_wdata,
	output logic        speaker,
	output note_t       cur_note,
	output logic        note_start
);

	cfg_t cfg;
	logic advance;

	player_regs i_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg       (cfg)
	);

	note_timer i_timer (
		.clk      (clk),
		.rst_n    (rst_n),
		.cfg      (cfg),
		.cur_note (cur_note),
		.advance  (advance)
	);

	score_ring i_ring (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg        (cfg),
		.advance    (advance),
		.cur_note   (cur_note),
		.note_start (note_start)
	);

	tone_gen #(
		.TONE_SHIFT (TONE_SHIFT)
	) i_tone (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg        (cfg),
		.cur_note   (cur_note),
		.note_start (note_start),
		.speaker    (speaker)
	);

endmodule

//--- tb/tb_music_player.sv
`timescale 1ns/1ps

module tb_music_player
	import music_pkg::*;
();

	localparam int MAX_PAUSES    = 12;
	localparam int PAUSE_MAX_LEN = 40;
	localparam int MAX_RESTARTS  = 3;
	localparam int MARGIN        = 1000;

	logic        clk;
	logic        rst_n;
	logic        cfg_we;
	logic [1:0]  cfg_addr;
	logic [15:0] cfg_wdata;
	logic        speaker;
	note_t       cur_note;
	logic        note_start;

	// Model state for the current cycle
	int    m_idx     = 0;     // Expected score entry
	int    m_elapsed = 0;     // Play cycles spent in this note
	int    m_tempo   = 1;
	logic  m_play    = 1'b0;
	logic  m_restart = 1'b0;
	logic  m_start   = 1'b0;
	logic  m_spk     = 1'b0;
	int    m_ph      = 0;     // Play cycles since the last toggle
	int    m_wraps   = 0;

	int    checks = 0;
	int    errors = 0;
	int    cycles = 0;
	int    cycle_limit;
	string test_name = "reset";

	music_player #(
		.TONE_SHIFT (0)
	) i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg_we     (cfg_we),
		.cfg_addr   (cfg_addr),
		.cfg_wdata  (cfg_wdata),
		.speaker    (speaker),
		.cur_note   (cur_note),
		.note_start (note_start)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic int score_beats();
		int sum;
		sum = 0;
		for (int i = 0; i < SCORE_LEN; i++)
			sum += int'(SCORE[i].dur) + 1;
		return sum;
	endfunction

	task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
		cfg_we    <= 1'b1;
		cfg_addr  <= addr;
		cfg_wdata <= data;
	endtask

	task automatic check_value(input string sig, input logic [15:0] exp_val,
		input logic [15:0] act_val);
		checks++;
		assert (act_val === exp_val)
		else
		begin
			errors++;
			$display("ERR %s %s: expected %0h, actual %0h", test_name, sig, exp_val, act_val);
		end
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	always @(negedge clk)
	begin
		note_t exp_note;
		int    half;
		int    note_len;
		if (rst_n)
		begin
			exp_note = SCORE[m_idx];
			half     = int'(HALF_PERIOD[exp_note.pitch]);
			note_len = (int'(exp_note.dur) + 1) * m_tempo;
			check_value("cur_note", 16'(exp_note), 16'(cur_note));
			check_value("note_start", 16'(m_start), 16'(note_start));
			check_value("speaker", 16'(m_spk), 16'(speaker));

			// Square wave is silent on rests and pauses
			if (m_start || exp_note.pitch == 4'd0)
			begin
				m_ph  = 0;
				m_spk = 1'b0;
			end
			else if (!m_play)
				m_spk = 1'b0;  // Phase is kept
			else if (m_ph == half - 1)
			begin
				m_ph  = 0;
				m_spk = !m_spk;
			end
			else
				m_ph++;

			// A note ends after (dur+1)*tempo play cycles
			m_start = 1'b0;
			if (m_restart)
			begin
				m_idx     = 0;
				m_elapsed = 0;
				m_start   = 1'b1;
			end
			else if (m_play)
			begin
				m_elapsed++;
				if (m_elapsed == note_len)
				begin
					m_elapsed = 0;
					m_start   = 1'b1;
					if (m_idx == SCORE_LEN - 1)
					begin
						m_idx = 0;
						m_wraps++;
					end
					else
						m_idx++;
				end
			end

			// Register write lands on the coming edge
			m_restart = 1'b0;
			if (cfg_we && cfg_addr == CFG_ADDR_CTRL)
			begin
				m_play    = cfg_wdata[0];
				m_restart = cfg_wdata[1];
			end
			if (cfg_we && cfg_addr == CFG_ADDR_TEMPO)
				m_tempo = (cfg_wdata == 16'd0) ? 1 : int'(cfg_wdata);
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
		begin
			$display("Timeout: score did not complete a full pass after %0d cycles", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial
	begin
		int pause_left;
		int pauses_done;
		int restarts_done;
		int note_len;
		pause_left    = 0;
		pauses_done   = 0;
		restarts_done = 0;
		rst_n     = 1'b0;
		cfg_we    = 1'b0;
		cfg_addr  = 2'd0;
		cfg_wdata = 16'd0;
		void'($urandom(32'he4be));
		cycle_limit = 2 * score_beats() * 4 + MAX_PAUSES * PAUSE_MAX_LEN + MARGIN;

		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);
		write_reg(CFG_ADDR_TEMPO, 16'($urandom_range(1, 4)));
		@(posedge clk);
		write_reg(CFG_ADDR_CTRL, 16'h0001);
		test_name = "note_order";

		while (m_wraps == 0 || m_idx < 3)
		begin
			@(posedge clk);
			cfg_we   <= 1'b0;
			note_len = (int'(SCORE[m_idx].dur) + 1) * m_tempo;
			if (pause_left > 0)
			begin
				pause_left--;
				if (pause_left == 0)
				begin
					write_reg(CFG_ADDR_CTRL, 16'h0001);
					test_name = "resume";
				end
			end
			else if (m_play && pauses_done < MAX_PAUSES && $urandom_range(0, 299) == 0)
			begin
				write_reg(CFG_ADDR_CTRL, 16'h0000);
				pause_left = $urandom_range(5, PAUSE_MAX_LEN);
				pauses_done++;
				test_name = "pause";
			end
			else if (m_play && !m_restart && restarts_done < MAX_RESTARTS && m_idx < 30 &&
				((restarts_done == 0 && m_idx == 20) || $urandom_range(0, 149) == 0))
			begin
				write_reg(CFG_ADDR_CTRL, 16'h0003);  // Restart and keep playing
				restarts_done++;
				test_name = "restart";
			end
			else if (m_play && !m_restart && m_elapsed + 1 == note_len &&
				$urandom_range(0, 3) == 0)
			begin
				// New tempo starts with the next note
				write_reg(CFG_ADDR_TEMPO, 16'($urandom_range(1, 4)));
				test_name = "tempo";
			end
		end

		@(posedge clk);
		cfg_we <= 1'b0;
		repeat (3) @(posedge clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- flist.f
rtl/music_pkg.sv
rtl/player_regs.sv
rtl/note_timer.sv
rtl/score_ring.sv
rtl/tone_gen.sv
rtl/music_player.sv
tb/tb_music_player.sv

//--- Makefile
# Verilator simulation of the tune player

VERILATOR ?= verilator
TOP       ?= tb_music_player
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Build, run, and pass only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)
